//--- iq_config.svh
/*
 * Sizing for the issue queue and register tracker.
 * IQ_DEPTH must be a power of two and IQ_TAG_W its log2.
 * IQ_REG_W must be wide enough to hold IQ_NREGS.
 * Register 0 is never a target and has no tracker state.
 */

`ifndef IQ_CONFIG_SVH
`define IQ_CONFIG_SVH

// Number of queue entries
`define IQ_DEPTH 8

// Entry index, also used as the instruction tag
`define IQ_TAG_W 3

// Highest register number tracked
`define IQ_NREGS 111

// Register number width
`define IQ_REG_W 7

`endif

//--- iq_pkg.sv
/*
 * Shared types for the issue queue project.
 * Widths come from the config macros.
 * Register masks are numbered 1 to IQ_NREGS with no bit for register 0.
 */

`default_nettype none

`include "iq_config.svh"

package iq_pkg;

	// Queue entry index, doubles as instruction tag
	typedef logic [`IQ_TAG_W-1:0] iq_tag_t;

	// Architectural register number
	typedef logic [`IQ_REG_W-1:0] iq_reg_t;

	// One bit per register, bit 0 left out
	typedef logic [`IQ_NREGS:1] iq_rmask_t;

	// One bit per queue entry
	typedef logic [`IQ_DEPTH-1:0] iq_emask_t;

endpackage

`default_nettype wire

//--- iq_livetarget.sv
/*
 * Live-target decode for the issue queue.
 * Purely combinational with no clock.
 * An entry counts only when valid, not stomped and writing its target.
 * Target 0 decodes to an empty mask.
 */

`default_nettype none

`include "iq_config.svh"

module iq_livetarget (
	input  wire iq_pkg::iq_emask_t                 iq_v,
	input  wire iq_pkg::iq_emask_t                 iq_stomp,
	input  wire iq_pkg::iq_emask_t                 iq_cmt,
	input  wire iq_pkg::iq_reg_t [`IQ_DEPTH-1:0]   iq_tgt,
	output iq_pkg::iq_rmask_t [`IQ_DEPTH-1:0]      entry_live,
	output iq_pkg::iq_rmask_t                      livetarget
);
	import iq_pkg::*;

	// OR of every entry mask
	iq_rmask_t live_any;

	// ========================================================================
	// Per-entry decode
	// ========================================================================
	for (genvar e = 0; e < `IQ_DEPTH; e++) begin : g_entry
		iq_rmask_t dec;
		logic      qual;

		// Entry still owes a write to its target
		assign qual = iq_v[e] & ~iq_stomp[e] & iq_cmt[e];

		// One-hot decode, register 0 has no bit
		always_comb begin
			dec = '0;
			for (int r = 1; r <= `IQ_NREGS; r++) begin
				if (iq_tgt[e] == iq_reg_t'(r))
					dec[r] = 1'b1;
			end
		end

		assign entry_live[e] = qual ? dec : '0;
	end

	// ========================================================================
	// Reduction over all entries
	// ========================================================================
	always_comb begin
		live_any = '0;
		for (int e = 0; e < `IQ_DEPTH; e++)
			live_any = live_any | entry_live[e];
	end

	assign livetarget = live_any;

endmodule

`default_nettype wire

//--- iq_queue.sv
/*
 * Circular issue queue, one dispatch and one retire per cycle.
 * branch_tag must name a valid in-flight entry when branch_miss is high.
 * Dispatch is refused while full or during a branch miss.
 * Commit record appears one cycle after the retiring edge.
 */

`default_nettype none

`include "iq_config.svh"

module iq_queue (
	input  wire                                  clk,
	input  wire                                  rst_n,
	// Dispatch
	input  wire                                  dispatch_valid,
	input  wire iq_pkg::iq_reg_t                 dispatch_reg,
	input  wire                                  dispatch_wr,
	output logic                                 dispatch_ready,
	output logic                                 dispatch_fire,
	output iq_pkg::iq_tag_t                      dispatch_tag,
	// Completion and branch miss
	input  wire                                  done_valid,
	input  wire iq_pkg::iq_tag_t                 done_tag,
	input  wire                                  branch_miss,
	input  wire iq_pkg::iq_tag_t                 branch_tag,
	// Entry state
	output iq_pkg::iq_tag_t                      head,
	output iq_pkg::iq_emask_t                    iq_v,
	output iq_pkg::iq_emask_t                    iq_stomp,
	output iq_pkg::iq_emask_t                    iq_cmt,
	output iq_pkg::iq_reg_t [`IQ_DEPTH-1:0]      iq_tgt,
	// Retire event
	output logic                                 retire_fire,
	output iq_pkg::iq_tag_t                      retire_tag,
	output iq_pkg::iq_reg_t                      retire_reg,
	output logic                                 retire_wr,
	// Commit record
	output logic                                 commit_valid,
	output iq_pkg::iq_tag_t                      commit_tag,
	output iq_pkg::iq_reg_t                      commit_reg,
	output logic                                 commit_wr
);
	import iq_pkg::*;

	localparam int CNT_W = `IQ_TAG_W + 1;

	iq_tag_t          tail;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_n;
	logic [CNT_W-1:0] nstomp;
	iq_emask_t        done;
	iq_emask_t        disp_oh;
	iq_emask_t        retire_oh;
	iq_emask_t        done_oh;

	// ========================================================================
	// Handshakes and events
	// ========================================================================
	assign dispatch_ready = (count != CNT_W'(`IQ_DEPTH)) && !branch_miss;
	assign dispatch_fire  = dispatch_valid && dispatch_ready;
	assign dispatch_tag   = tail;

	// Oldest entry leaves once done and not stomped
	assign retire_fire = iq_v[head] && done[head] && !iq_stomp[head];
	assign retire_tag  = head;
	assign retire_reg  = iq_tgt[head];
	assign retire_wr   = iq_cmt[head];

	assign disp_oh   = dispatch_fire ? iq_emask_t'(1) << tail : '0;
	assign retire_oh = retire_fire ? iq_emask_t'(1) << head : '0;

	// Completions to dead or dying entries are dropped
	assign done_oh = (done_valid && iq_v[done_tag] && !iq_stomp[done_tag]) ?
		iq_emask_t'(1) << done_tag : '0;

	// ========================================================================
	// Stomp mask
	// ========================================================================
	// Walk from the entry after the branch until the tail
	always_comb begin
		iq_tag_t idx;
		logic    run;

		iq_stomp = '0;
		run      = branch_miss;
		for (int i = 1; i < `IQ_DEPTH; i++) begin
			idx = branch_tag + iq_tag_t'(i);
			if (idx == tail)
				run = 1'b0;
			if (run && iq_v[idx])
				iq_stomp[idx] = 1'b1;
		end
	end

	// Occupancy after this edge
	always_comb begin
		nstomp = '0;
		for (int i = 0; i < `IQ_DEPTH; i++)
			nstomp = nstomp + CNT_W'(iq_stomp[i]);
		count_n = count + CNT_W'(dispatch_fire) - CNT_W'(retire_fire) - nstomp;
	end

	// ========================================================================
	// Control state
	// ========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			iq_v         <= '0;
			done         <= '0;
			commit_valid <= 1'b0;
		end else begin
			count        <= count_n;
			iq_v         <= (iq_v & ~iq_stomp & ~retire_oh) | disp_oh;
			done         <= (done | done_oh) & ~disp_oh;
			commit_valid <= retire_fire;
			if (retire_fire)
				head <= head + 1'b1;
			// Tail snaps back to just past the branch
			if (branch_miss)
				tail <= branch_tag + 1'b1;
			else if (dispatch_fire)
				tail <= tail + 1'b1;
		end
	end

	// Payload written on dispatch and captured on retire
	always_ff @(posedge clk) begin
		if (dispatch_fire) begin
			iq_tgt[tail] <= dispatch_reg;
			iq_cmt[tail] <= dispatch_wr;
		end
		if (retire_fire) begin
			commit_tag <= head;
			commit_reg <= iq_tgt[head];
			commit_wr  <= iq_cmt[head];
		end
	end

endmodule

`default_nettype wire

//--- iq_reg_tracker.sv
/*
 * Register validity and source tag tracker.
 * Updates apply in sequence at one edge, flush repair then dispatch then retire.
 * Flush repair relies on the live-target masks of the same cycle.
 * Register 0 and numbers above IQ_NREGS read valid with tag 0.
 */

`default_nettype none

`include "iq_config.svh"

module iq_reg_tracker (
	input  wire                                    clk,
	input  wire                                    rst_n,
	// Dispatch event
	input  wire                                    dispatch_fire,
	input  wire iq_pkg::iq_tag_t                   dispatch_tag,
	input  wire iq_pkg::iq_reg_t                   dispatch_reg,
	input  wire                                    dispatch_wr,
	// Retire event
	input  wire                                    retire_fire,
	input  wire iq_pkg::iq_tag_t                   retire_tag,
	input  wire iq_pkg::iq_reg_t                   retire_reg,
	input  wire                                    retire_wr,
	// Flush repair
	input  wire                                    branch_miss,
	input  wire iq_pkg::iq_rmask_t [`IQ_DEPTH-1:0] entry_live,
	input  wire iq_pkg::iq_rmask_t                 livetarget,
	input  wire iq_pkg::iq_tag_t                   head,
	// Query
	input  wire iq_pkg::iq_reg_t                   rd_reg,
	output logic                                   rd_valid,
	output iq_pkg::iq_tag_t                        rd_tag
);
	import iq_pkg::*;

	iq_rmask_t                   rf_v;
	iq_rmask_t                   v_n;
	iq_tag_t [`IQ_NREGS:1]       rf_src;
	iq_tag_t [`IQ_NREGS:1]       src_n;
	iq_tag_t [`IQ_NREGS:1]       youngest;
	logic                        rd_in_range;

	// ========================================================================
	// Youngest surviving writer per register
	// ========================================================================
	// Scan oldest to youngest so the last hit wins
	always_comb begin
		iq_tag_t e;

		youngest = '0;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			e = head + iq_tag_t'(i);
			for (int r = 1; r <= `IQ_NREGS; r++) begin
				if (entry_live[e][r])
					youngest[r] = e;
			end
		end
	end

	// ========================================================================
	// Next state
	// ========================================================================
	always_comb begin
		v_n   = rf_v;
		src_n = rf_src;

		// Flush repair
		if (branch_miss) begin
			v_n = ~livetarget;
			for (int r = 1; r <= `IQ_NREGS; r++) begin
				if (livetarget[r])
					src_n[r] = youngest[r];
			end
		end

		// New writer takes ownership
		if (dispatch_fire && dispatch_wr && dispatch_reg != '0) begin
			v_n[dispatch_reg]   = 1'b0;
			src_n[dispatch_reg] = dispatch_tag;
		end

		// Only the newest writer frees the register
		if (retire_fire && retire_wr && retire_reg != '0) begin
			if (src_n[retire_reg] == retire_tag)
				v_n[retire_reg] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rf_v   <= '1;
			rf_src <= '0;
		end else begin
			rf_v   <= v_n;
			rf_src <= src_n;
		end
	end

	// ========================================================================
	// Query port
	// ========================================================================
	assign rd_in_range = (rd_reg != '0) && (rd_reg <= iq_reg_t'(`IQ_NREGS));
	assign rd_valid    = rd_in_range ? rf_v[rd_reg] : 1'b1;
	assign rd_tag      = rd_in_range ? rf_src[rd_reg] : '0;

endmodule

`default_nettype wire

//--- iq_top.sv
/*
 * Issue queue with live-target tracking of register results.
 * Dispatch uses valid/ready, completion and branch miss are strobes.
 * Commit output has no back-pressure.
 */

`default_nettype none

`include "iq_config.svh"

module iq_top (
	input  wire                   clk,
	input  wire                   rst_n,
	// Dispatch
	input  wire                   dispatch_valid,
	input  wire iq_pkg::iq_reg_t  dispatch_reg,
	input  wire                   dispatch_wr,
	output logic                  dispatch_ready,
	output iq_pkg::iq_tag_t       dispatch_tag,
	// Completion and branch miss
	input  wire                   done_valid,
	input  wire iq_pkg::iq_tag_t  done_tag,
	input  wire                   branch_miss,
	input  wire iq_pkg::iq_tag_t  branch_tag,
	// Commit
	output logic                  commit_valid,
	output iq_pkg::iq_tag_t       commit_tag,
	output iq_pkg::iq_reg_t       commit_reg,
	output logic                  commit_wr,
	// Register query
	input  wire iq_pkg::iq_reg_t  rd_reg,
	output logic                  rd_valid,
	output iq_pkg::iq_tag_t       rd_tag
);
	import iq_pkg::*;

	// Queue to live-target
	iq_emask_t                    iq_v;
	iq_emask_t                    iq_stomp;
	iq_emask_t                    iq_cmt;
	iq_reg_t [`IQ_DEPTH-1:0]      iq_tgt;

	// Live-target to tracker
	iq_rmask_t [`IQ_DEPTH-1:0]    entry_live;
	iq_rmask_t                    livetarget;

	// Queue events to tracker
	logic                         dispatch_fire;
	iq_tag_t                      head;
	logic                         retire_fire;
	iq_tag_t                      retire_tag;
	iq_reg_t                      retire_reg;
	logic                         retire_wr;

	iq_queue i_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_reg   (dispatch_reg),
		.dispatch_wr    (dispatch_wr),
		.dispatch_ready (dispatch_ready),
		.dispatch_fire  (dispatch_fire),
		.dispatch_tag   (dispatch_tag),
		.done_valid     (done_valid),
		.done_tag       (done_tag),
		.branch_miss    (branch_miss),
		.branch_tag     (branch_tag),
		.head           (head),
		.iq_v           (iq_v),
		.iq_stomp       (iq_stomp),
		.iq_cmt         (iq_cmt),
		.iq_tgt         (iq_tgt),
		.retire_fire    (retire_fire),
		.retire_tag     (retire_tag),
		.retire_reg     (retire_reg),
		.retire_wr      (retire_wr),
		.commit_valid   (commit_valid),
		.commit_tag     (commit_tag),
		.commit_reg     (commit_reg),
		.commit_wr      (commit_wr)
	);

	iq_livetarget i_livetarget (
		.iq_v       (iq_v),
		.iq_stomp   (iq_stomp),
		.iq_cmt     (iq_cmt),
		.iq_tgt     (iq_tgt),
		.entry_live (entry_live),
		.livetarget (livetarget)
	);

	iq_reg_tracker i_reg_tracker (
		.clk           (clk),
		.rst_n         (rst_n),
		.dispatch_fire (dispatch_fire),
		.dispatch_tag  (dispatch_tag),
		.dispatch_reg  (dispatch_reg),
		.dispatch_wr   (dispatch_wr),
		.retire_fire   (retire_fire),
		.retire_tag    (retire_tag),
		.retire_reg    (retire_reg),
		.retire_wr     (retire_wr),
		.branch_miss   (branch_miss),
		.entry_live    (entry_live),
		.livetarget    (livetarget),
		.head          (head),
		.rd_reg        (rd_reg),
		.rd_valid      (rd_valid),
		.rd_tag        (rd_tag)
	);

endmodule

`default_nettype wire

//--- iq_checker.sv
/*
 * Assertions bound into iq_top.
 * Commits must walk tags in order and never retire a stomped entry.
 * Dispatch is refused while full or during a branch miss.
 * err_count counts failed assertions.
 */

`default_nettype none

`include "iq_config.svh"

module iq_checker (
	input wire                     clk,
	input wire                     rst_n,
	input wire                     dispatch_valid,
	input wire                     dispatch_ready,
	input wire                     dispatch_fire,
	input wire iq_pkg::iq_tag_t    dispatch_tag,
	input wire iq_pkg::iq_reg_t    dispatch_reg,
	input wire                     dispatch_wr,
	input wire                     branch_miss,
	input wire iq_pkg::iq_emask_t  iq_v,
	input wire iq_pkg::iq_emask_t  iq_stomp,
	input wire                     retire_fire,
	input wire iq_pkg::iq_tag_t    retire_tag,
	input wire                     commit_valid,
	input wire iq_pkg::iq_tag_t    commit_tag
);
	import iq_pkg::*;

	int unsigned err_count = 0;

	// Tags stomped and not yet handed out again
	iq_emask_t dead;
	iq_tag_t   last_tag;
	logic      seen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dead     <= '0;
			last_tag <= '0;
			seen     <= 1'b0;
		end else begin
			dead <= (dead | iq_stomp) &
				~(dispatch_fire ? iq_emask_t'(1) << dispatch_tag : iq_emask_t'(0));
			if (commit_valid) begin
				last_tag <= commit_tag;
				seen     <= 1'b1;
			end
		end
	end

	// ========================================================================
	// Properties
	// ========================================================================
	a_commit_order: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid && seen |-> commit_tag == iq_tag_t'(last_tag + 1'b1))
		else begin
			$error("Commit tag skipped or repeated");
			err_count++;
		end

	// A stomped entry never retires
	a_no_dead_retire: assert property (@(posedge clk) disable iff (!rst_n)
		retire_fire |-> !dead[retire_tag])
		else begin
			$error("Stomped entry retired");
			err_count++;
		end

	a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
		&iq_v |-> !dispatch_ready)
		else begin
			$error("Dispatch ready with queue full");
			err_count++;
		end

	a_ready_branch: assert property (@(posedge clk) disable iff (!rst_n)
		branch_miss |-> !dispatch_ready)
		else begin
			$error("Dispatch ready during branch miss");
			err_count++;
		end

	// Under back-pressure the request stays put
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dispatch_valid && !dispatch_ready |=>
			dispatch_valid && $stable(dispatch_reg) && $stable(dispatch_wr))
		else begin
			$error("Dispatch request changed before transfer");
			err_count++;
		end

endmodule

`default_nettype wire

//--- tb_iq_top.sv
/*
 * Random testbench for iq_top with a reference model of queue and registers.
 * Checks are concurrent assertions sampled on the rising clock edge.
 * branch_miss is only raised on a tag that is in flight.
 * Dispatch targets stay within 1 to IQ_NREGS.
 */

`default_nettype none

`include "iq_config.svh"

module tb_iq_top;
	import iq_pkg::*;

	localparam int NUM_PHASES      = 5;
	localparam int PHASE_CYCLES    = 600;
	localparam int WATCHDOG_CYCLES = NUM_PHASES * PHASE_CYCLES + 1000;

	// Per-phase traffic mix in percent and highest target register
	localparam int DISP_PCT [NUM_PHASES] = '{90, 70, 60, 80, 50};
	localparam int DONE_PCT [NUM_PHASES] = '{10, 60, 50, 40, 70};
	localparam int BR_PCT   [NUM_PHASES] = '{0, 3, 15, 8, 5};
	localparam int REG_HI   [NUM_PHASES] = '{111, 111, 4, 8, 111};

	logic    clk;
	logic    rst_n;
	logic    dispatch_valid;
	iq_reg_t dispatch_reg;
	logic    dispatch_wr;
	logic    dispatch_ready;
	iq_tag_t dispatch_tag;
	logic    done_valid;
	iq_tag_t done_tag;
	logic    branch_miss;
	iq_tag_t branch_tag;
	logic    commit_valid;
	iq_tag_t commit_tag;
	iq_reg_t commit_reg;
	logic    commit_wr;
	iq_reg_t rd_reg;
	logic    rd_valid;
	iq_tag_t rd_tag;

	// ========================================================================
	// Reference model state
	// ========================================================================
	// In-flight tags ordered oldest to youngest
	int      inflight[$];
	logic    m_done [`IQ_DEPTH];
	iq_reg_t m_reg [`IQ_DEPTH];
	logic    m_wr [`IQ_DEPTH];
	iq_tag_t m_tail;
	logic    last_fire;
	logic    r_valid [`IQ_NREGS+1];
	iq_tag_t r_src [`IQ_NREGS+1];

	// Expected outputs for the cycle after each edge
	logic    exp_ready;
	iq_tag_t exp_tag;
	logic    exp_cv;
	iq_tag_t exp_ctag;
	iq_reg_t exp_creg;
	logic    exp_cwr;
	logic    exp_rd_valid;
	iq_tag_t exp_rd_tag;

	iq_top i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_reg   (dispatch_reg),
		.dispatch_wr    (dispatch_wr),
		.dispatch_ready (dispatch_ready),
		.dispatch_tag   (dispatch_tag),
		.done_valid     (done_valid),
		.done_tag       (done_tag),
		.branch_miss    (branch_miss),
		.branch_tag     (branch_tag),
		.commit_valid   (commit_valid),
		.commit_tag     (commit_tag),
		.commit_reg     (commit_reg),
		.commit_wr      (commit_wr),
		.rd_reg         (rd_reg),
		.rd_valid       (rd_valid),
		.rd_tag         (rd_tag)
	);

	bind iq_top iq_checker i_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_ready (dispatch_ready),
		.dispatch_fire  (dispatch_fire),
		.dispatch_tag   (dispatch_tag),
		.dispatch_reg   (dispatch_reg),
		.dispatch_wr    (dispatch_wr),
		.branch_miss    (branch_miss),
		.iq_v           (iq_v),
		.iq_stomp       (iq_stomp),
		.retire_fire    (retire_fire),
		.retire_tag     (retire_tag),
		.commit_valid   (commit_valid),
		.commit_tag     (commit_tag)
	);

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
		abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// ========================================================================
	// Model update for one rising edge
	// ========================================================================
	task automatic model_edge();
		int      pos;
		int      tag;
		logic    retire;
		iq_tag_t rtag;
		logic    live [`IQ_NREGS+1];

		// Entries at positions below pos survive this edge
		pos = inflight.size();
		if (branch_miss) begin
			for (int i = 0; i < inflight.size(); i++) begin
				if (inflight[i] == int'(branch_tag))
					pos = i + 1;
			end
		end
		last_fire = dispatch_valid && inflight.size() < `IQ_DEPTH && !branch_miss;
		retire    = inflight.size() > 0 && m_done[inflight[0]];
		rtag      = iq_tag_t'(retire ? inflight[0] : 0);

		// Completion only lands on a surviving entry
		if (done_valid) begin
			for (int i = 0; i < pos; i++) begin
				if (inflight[i] == int'(done_tag))
					m_done[done_tag] = 1'b1;
			end
		end

		// Flush repair gives each register to its youngest surviving writer
		if (branch_miss) begin
			for (int r = 1; r <= `IQ_NREGS; r++)
				live[r] = 1'b0;
			for (int i = 0; i < pos; i++) begin
				tag = inflight[i];
				if (m_wr[tag]) begin
					live[m_reg[tag]]  = 1'b1;
					r_src[m_reg[tag]] = iq_tag_t'(tag);
				end
			end
			for (int r = 1; r <= `IQ_NREGS; r++)
				r_valid[r] = !live[r];
			while (inflight.size() > pos)
				void'(inflight.pop_back());
			m_tail = branch_tag + 1'b1;
		end

		if (last_fire) begin
			m_reg[m_tail]  = dispatch_reg;
			m_wr[m_tail]   = dispatch_wr;
			m_done[m_tail] = 1'b0;
			inflight.push_back(int'(m_tail));
			if (dispatch_wr) begin
				r_valid[dispatch_reg] = 1'b0;
				r_src[dispatch_reg]   = m_tail;
			end
			m_tail = m_tail + 1'b1;
		end

		// Retire frees the register only for its newest writer
		if (retire) begin
			void'(inflight.pop_front());
			if (m_wr[rtag] && r_src[m_reg[rtag]] == rtag)
				r_valid[m_reg[rtag]] = 1'b1;
			exp_ctag <= rtag;
			exp_creg <= m_reg[rtag];
			exp_cwr  <= m_wr[rtag];
		end
		exp_cv <= retire;
	endtask

	// ========================================================================
	// Stimulus for the next cycle
	// ========================================================================
	task automatic drive_next(int p, int c);
		logic    nb;
		iq_reg_t nrd;

		nb  = inflight.size() > 0 && $urandom_range(99) < BR_PCT[p];
		nrd = (rd_reg >= iq_reg_t'(REG_HI[p])) ? '0 : rd_reg + 1'b1;

		// Fields stay put until the DUT takes them
		if (!dispatch_valid || last_fire) begin
			// First sweep after reset reads every register with no traffic
			dispatch_valid <= (p > 0 || c >= `IQ_NREGS) &&
				$urandom_range(99) < DISP_PCT[p];
			dispatch_reg   <= iq_reg_t'($urandom_range(REG_HI[p], 1));
			dispatch_wr    <= $urandom_range(3) != 0;
		end

		done_valid <= inflight.size() > 0 && $urandom_range(99) < DONE_PCT[p];
		// Some completions aim at tags no longer in flight
		if ($urandom_range(7) == 0 || inflight.size() == 0)
			done_tag <= iq_tag_t'($urandom_range(7));
		else
			done_tag <= iq_tag_t'(inflight[$urandom_range(inflight.size() - 1)]);

		branch_miss <= nb;
		if (nb)
			branch_tag <= iq_tag_t'(inflight[$urandom_range(inflight.size() - 1)]);

		rd_reg       <= nrd;
		exp_ready    <= inflight.size() < `IQ_DEPTH && !nb;
		exp_tag      <= m_tail;
		exp_rd_valid <= (nrd == '0) ? 1'b1 : r_valid[nrd];
		exp_rd_tag   <= (nrd == '0) ? '0 : r_src[nrd];
	endtask

	// ========================================================================
	// Checks
	// ========================================================================
	a_ready: assert property (@(posedge clk) disable iff (!rst_n)
		dispatch_ready == exp_ready)
		else mismatch("dispatch_ready", $sampled(dispatch_ready), $sampled(exp_ready));

	a_dtag: assert property (@(posedge clk) disable iff (!rst_n)
		dispatch_tag == exp_tag)
		else mismatch("dispatch_tag", $sampled(dispatch_tag), $sampled(exp_tag));

	a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid == exp_rd_valid)
		else mismatch("rd_valid", $sampled(rd_valid), $sampled(exp_rd_valid));

	a_rd_tag: assert property (@(posedge clk) disable iff (!rst_n)
		rd_tag == exp_rd_tag)
		else mismatch("rd_tag", $sampled(rd_tag), $sampled(exp_rd_tag));

	a_cvalid: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid == exp_cv)
		else mismatch("commit_valid", $sampled(commit_valid), $sampled(exp_cv));

	// Record packed as tag, reg, wr
	a_crecord: assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid |-> {commit_tag, commit_reg, commit_wr} == {exp_ctag, exp_creg, exp_cwr})
		else mismatch("commit_tag/commit_reg/commit_wr",
			$sampled({commit_tag, commit_reg, commit_wr}),
			$sampled({exp_ctag, exp_creg, exp_cwr}));

	always @(negedge clk) begin
		if (i_dut.i_checker.err_count != 0)
			abort_run("A checker assertion on the issue queue failed");
	end

	// ========================================================================
	// Clock, reset, run and watchdog
	// ========================================================================
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Watchdog expired before the test finished");
	end

	initial begin
		void'($urandom(32'h7026));
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_reg   = '0;
		dispatch_wr    = 1'b0;
		done_valid     = 1'b0;
		done_tag       = '0;
		branch_miss    = 1'b0;
		branch_tag     = '0;
		rd_reg         = '0;
		// Model matches the DUT reset state
		m_tail    = '0;
		last_fire = 1'b0;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			m_done[i] = 1'b0;
			m_reg[i]  = '0;
			m_wr[i]   = 1'b0;
		end
		for (int r = 0; r <= `IQ_NREGS; r++) begin
			r_valid[r] = 1'b1;
			r_src[r]   = '0;
		end
		exp_ready    = 1'b1;
		exp_tag      = '0;
		exp_cv       = 1'b0;
		exp_ctag     = '0;
		exp_creg     = '0;
		exp_cwr      = 1'b0;
		exp_rd_valid = 1'b1;
		exp_rd_tag   = '0;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		for (int p = 0; p < NUM_PHASES; p++) begin
			for (int c = 0; c < PHASE_CYCLES; c++) begin
				@(posedge clk);
				model_edge();
				drive_next(p, c);
			end
		end
		// Last sampled edge settles before the verdict
		@(posedge clk);
		@(negedge clk);

		if (i_dut.i_checker.err_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			abort_run("A checker assertion on the issue queue failed");
		end
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
iq_pkg.sv
iq_livetarget.sv
iq_queue.sv
iq_reg_tracker.sv
iq_top.sv
iq_checker.sv
tb_iq_top.sv
